// File: hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

   localparam int DATA_W    = 32;
   localparam int REG_AW    = 5;
   localparam int OFFSET_W  = 16;
   localparam int MEM_WORDS = 64;
   localparam int MEM_AW    = $clog2(MEM_WORDS);

   localparam logic [DATA_W-1:0] RESET_PC = 32'h0000_0100;
   // vector for cause n sits at EXC_BASE + n * 0x100
   localparam logic [DATA_W-1:0] EXC_BASE = 32'h0000_0000;

   // values above OPC_TRAP are illegal
   typedef enum logic [4:0] {
      OPC_NOP   = 5'd0,
      OPC_ADD   = 5'd1,
      OPC_SUB   = 5'd2,
      OPC_AND   = 5'd3,
      OPC_OR    = 5'd4,
      OPC_XOR   = 5'd5,
      OPC_SLL   = 5'd6,
      OPC_SRL   = 5'd7,
      OPC_MUL   = 5'd8,
      OPC_SFEQ  = 5'd9,
      OPC_SFLTU = 5'd10,
      OPC_LW    = 5'd11,
      OPC_SW    = 5'd12,
      OPC_JR    = 5'd13,
      OPC_SYS   = 5'd14,
      OPC_TRAP  = 5'd15
   } opcode_e;

   typedef struct packed {
      opcode_e           opc;
      logic [REG_AW-1:0] rd;
      logic [21:0]       spare;
   } insn_alu_s;

   // loads and stores also read the offset field
   typedef struct packed {
      opcode_e                     opc;
      logic [REG_AW-1:0]           rd;
      logic [5:0]                  spare;
      logic signed [OFFSET_W-1:0]  offset;
   } insn_mem_s;

   typedef union packed {
      insn_alu_s alu;
      insn_mem_s mem;
   } insn_u;

   typedef struct packed {
      logic ibus_err;
      logic ibus_align;
      logic illegal;
      logic syscall;
      logic trap;
      logic dbus;
      logic align;
   } except_s;

   // lower number wins
   typedef enum logic [2:0] {
      CAUSE_NONE       = 3'd0,
      CAUSE_IBUS_ERR   = 3'd1,
      CAUSE_IBUS_ALIGN = 3'd2,
      CAUSE_ILLEGAL    = 3'd3,
      CAUSE_SYSCALL    = 3'd4,
      CAUSE_TRAP       = 3'd5,
      CAUSE_DBUS       = 3'd6,
      CAUSE_ALIGN      = 3'd7
   } cause_e;

endpackage

`default_nettype wire

// File: hdl/exec_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

// control-stage contents passed from the stage register to commit
interface exec_ctrl_if;
   import exec_pkg::*;

   logic              valid;
   opcode_e           opc;
   logic [REG_AW-1:0] rd;
   logic [DATA_W-1:0] result;
   logic [DATA_W-1:0] rfb;
   logic              flag_set;
   logic              flag_clear;
   logic [DATA_W-1:0] pc;
   except_s           exc;
   logic              wb;
   // commit clears the stage on an exception
   logic              flush;

   modport stage (
      output valid, opc, rd, result, rfb, flag_set, flag_clear, pc, exc, wb,
      input  flush
   );

   modport commit (
      input  valid, opc, rd, result, rfb, flag_set, flag_clear, pc, exc, wb,
      output flush
   );

endinterface

`default_nettype wire

// File: hdl/exec_alu.sv
`timescale 1ns/100ps
`default_nettype none

module exec_alu (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic                      start_i,
   input  wire exec_pkg::opcode_e         opc_i,
   input  wire logic [exec_pkg::DATA_W-1:0] opa_i,
   input  wire logic [exec_pkg::DATA_W-1:0] opb_i,
   output logic [exec_pkg::DATA_W-1:0]    result_o,
   output logic                           valid_o,
   output logic                           flag_set_o,
   output logic                           flag_clear_o
);
   import exec_pkg::*;

   logic              mul_start;
   logic              mul_run_q;
   logic              mul_done_q;
   logic [4:0]        mul_left_q;
   logic [DATA_W-1:0] mul_acc_q;
   logic [DATA_W-1:0] mul_mcand_q;
   logic [DATA_W-1:0] mul_mplier_q;
   logic              cmp_true;
   logic              is_cmp;

   assign mul_start = start_i && (opc_i == OPC_MUL);

   // the start cycle already does the first of 32 steps
   always_ff @(posedge clk) begin
      if (mul_start) begin
         mul_acc_q    <= opb_i[0] ? opa_i : '0;
         mul_mcand_q  <= opa_i << 1;
         mul_mplier_q <= opb_i >> 1;
      end else if (mul_run_q) begin
         mul_acc_q    <= mul_acc_q + (mul_mplier_q[0] ? mul_mcand_q : '0);
         mul_mcand_q  <= mul_mcand_q << 1;
         mul_mplier_q <= mul_mplier_q >> 1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mul_run_q  <= 1'b0;
         mul_done_q <= 1'b0;
         mul_left_q <= '0;
      end else if (mul_start) begin
         mul_run_q  <= 1'b1;
         mul_done_q <= 1'b0;
         mul_left_q <= 5'd31;
      end else if (mul_run_q) begin
         mul_left_q <= mul_left_q - 5'd1;
         if (mul_left_q == 5'd1) begin
            mul_run_q  <= 1'b0;
            mul_done_q <= 1'b1;
         end
      end else begin
         // done is a one-cycle pulse that the stage register takes at once
         mul_done_q <= 1'b0;
      end
   end

   always_comb begin
      case (opc_i)
         OPC_ADD: result_o = opa_i + opb_i;
         OPC_SUB: result_o = opa_i - opb_i;
         OPC_AND: result_o = opa_i & opb_i;
         OPC_OR:  result_o = opa_i | opb_i;
         OPC_XOR: result_o = opa_i ^ opb_i;
         OPC_SLL: result_o = opa_i << opb_i[4:0];
         OPC_SRL: result_o = opa_i >> opb_i[4:0];
         OPC_MUL: result_o = mul_acc_q;
         default: result_o = '0;
      endcase
   end

   assign is_cmp   = (opc_i == OPC_SFEQ) || (opc_i == OPC_SFLTU);
   assign cmp_true = (opc_i == OPC_SFEQ) ? (opa_i == opb_i) : (opa_i < opb_i);

   assign flag_set_o   = is_cmp && cmp_true;
   assign flag_clear_o = is_cmp && !cmp_true;

   assign valid_o = (opc_i == OPC_MUL) ? mul_done_q : 1'b1;

   // a new instruction must wait for the multiply to finish
   a_no_start_in_mul: assert property (@(posedge clk) disable iff (rst)
      start_i |-> !mul_run_q);

endmodule

`default_nettype wire

// File: hdl/exec_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module exec_lsu (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          start_i,
   input  wire exec_pkg::opcode_e             opc_i,
   input  wire logic [exec_pkg::DATA_W-1:0]   opa_i,
   input  wire logic [exec_pkg::OFFSET_W-1:0] offset_i,
   input  wire logic [exec_pkg::DATA_W-1:0]   store_data_i,
   output logic [exec_pkg::DATA_W-1:0]        load_data_o,
   output logic                               valid_o,
   output logic                               except_align_o,
   output logic                               except_dbus_o
);
   import exec_pkg::*;

   logic [DATA_W-1:0] mem [MEM_WORDS];
   logic [DATA_W-1:0] addr;
   logic [MEM_AW-1:0] word_idx;
   logic              is_load;
   logic              is_store;
   logic              mem_exc;
   logic              start_q;
   logic [DATA_W-1:0] load_q;

   assign is_load  = (opc_i == OPC_LW);
   assign is_store = (opc_i == OPC_SW);

   // effective address with the offset sign extended
   assign addr     = opa_i + {{(DATA_W-OFFSET_W){offset_i[OFFSET_W-1]}}, offset_i};
   assign word_idx = addr[MEM_AW+1:2];

   assign except_align_o = (is_load || is_store) && (addr[1:0] != 2'b00);
   assign except_dbus_o  = (is_load || is_store) && (addr >= DATA_W'(MEM_WORDS * 4));
   assign mem_exc        = except_align_o || except_dbus_o;

   // a faulting store leaves memory untouched
   always_ff @(posedge clk) begin
      if (start_i && is_store && !mem_exc) begin
         mem[word_idx] <= store_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (start_i && is_load && !mem_exc) begin
         load_q <= mem[word_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         start_q <= 1'b0;
      end else begin
         start_q <= start_i && (is_load || is_store);
      end
   end

   assign load_data_o = load_q;
   // read data is ready one cycle after the access starts
   assign valid_o     = start_q;

endmodule

`default_nettype wire

// File: hdl/execute_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module execute_ctrl (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire logic                        issue_i,
   input  wire exec_pkg::insn_u             insn_i,
   input  wire logic [exec_pkg::DATA_W-1:0] opa_i,
   input  wire logic [exec_pkg::DATA_W-1:0] opb_i,
   input  wire logic [exec_pkg::DATA_W-1:0] pc_i,
   input  wire logic                        ibus_err_i,
   output logic                             busy_o,
   exec_ctrl_if.stage                       ctrl
);
   import exec_pkg::*;

   // execute register for an instruction that needs more than one cycle
   logic              held_q;
   insn_u             held_insn;
   logic [DATA_W-1:0] held_opa;
   logic [DATA_W-1:0] held_opb;
   logic [DATA_W-1:0] held_pc;
   logic              held_ibus_err;

   insn_u             cur_insn;
   logic [DATA_W-1:0] cur_opa;
   logic [DATA_W-1:0] cur_opb;
   logic [DATA_W-1:0] cur_pc;
   logic              cur_ibus_err;
   opcode_e           cur_opc;

   logic              is_alu;
   logic              is_mem;
   logic              bubble;
   logic              advance;
   logic              unit_valid;
   except_s           exc;

   logic [DATA_W-1:0] alu_result;
   logic              alu_valid;
   logic              alu_flag_set;
   logic              alu_flag_clear;
   logic [DATA_W-1:0] lsu_load_data;
   logic              lsu_valid;
   logic              lsu_align;
   logic              lsu_dbus;

   always_ff @(posedge clk) begin
      if (issue_i) begin
         held_insn     <= insn_i;
         held_opa      <= opa_i;
         held_opb      <= opb_i;
         held_pc       <= pc_i;
         held_ibus_err <= ibus_err_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         held_q <= 1'b0;
      end else if (advance) begin
         held_q <= 1'b0;
      end else if (issue_i) begin
         held_q <= 1'b1;
      end
   end

   // the issue cycle works straight from the ports
   assign cur_insn     = held_q ? held_insn : insn_i;
   assign cur_opa      = held_q ? held_opa : opa_i;
   assign cur_opb      = held_q ? held_opb : opb_i;
   assign cur_pc       = held_q ? held_pc : pc_i;
   assign cur_ibus_err = held_q ? held_ibus_err : ibus_err_i;
   assign cur_opc      = cur_insn.alu.opc;

   assign is_alu = (cur_opc >= OPC_ADD) && (cur_opc <= OPC_MUL);
   assign is_mem = (cur_opc == OPC_LW) || (cur_opc == OPC_SW);
   // a NOP moves through as a bubble and carries nothing to commit
   assign bubble = (cur_opc == OPC_NOP);

   assign unit_valid = is_alu ? alu_valid : is_mem ? lsu_valid : 1'b1;
   assign advance    = (issue_i || held_q) && unit_valid;

   exec_alu u_alu (
      .clk          (clk),
      .rst          (rst),
      .start_i      (issue_i),
      .opc_i        (cur_opc),
      .opa_i        (cur_opa),
      .opb_i        (cur_opb),
      .result_o     (alu_result),
      .valid_o      (alu_valid),
      .flag_set_o   (alu_flag_set),
      .flag_clear_o (alu_flag_clear)
   );

   exec_lsu u_lsu (
      .clk            (clk),
      .rst            (rst),
      .start_i        (issue_i),
      .opc_i          (cur_opc),
      .opa_i          (cur_opa),
      .offset_i       (cur_insn.mem.offset),
      .store_data_i   (cur_opb),
      .load_data_o    (lsu_load_data),
      .valid_o        (lsu_valid),
      .except_align_o (lsu_align),
      .except_dbus_o  (lsu_dbus)
   );

   always_comb begin
      exc            = '0;
      exc.ibus_err   = cur_ibus_err;
      exc.ibus_align = (cur_opc == OPC_JR) && (cur_opb[1:0] != 2'b00);
      exc.illegal    = (cur_opc > OPC_TRAP);
      exc.syscall    = (cur_opc == OPC_SYS);
      exc.trap       = (cur_opc == OPC_TRAP);
      exc.dbus       = lsu_dbus;
      exc.align      = lsu_align;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl.valid      <= 1'b0;
         ctrl.opc        <= OPC_NOP;
         ctrl.rfb        <= '0;
         ctrl.exc        <= '0;
         ctrl.flag_set   <= 1'b0;
         ctrl.flag_clear <= 1'b0;
         ctrl.wb         <= 1'b0;
      end else if (ctrl.flush) begin
         ctrl.valid <= 1'b0;
         ctrl.opc   <= OPC_NOP;
         ctrl.rfb   <= '0;
         ctrl.exc   <= '0;
      end else begin
         ctrl.valid <= advance && !bubble;
         if (advance) begin
            ctrl.opc        <= cur_opc;
            ctrl.rfb        <= cur_opb;
            ctrl.exc        <= exc;
            ctrl.flag_set   <= alu_flag_set;
            ctrl.flag_clear <= alu_flag_clear;
            ctrl.wb         <= is_alu || ((cur_opc == OPC_LW) && !lsu_dbus && !lsu_align);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         ctrl.rd     <= cur_insn.alu.rd;
         ctrl.result <= (cur_opc == OPC_LW) ? lsu_load_data : alu_result;
      end
   end

   // bubbles keep the previous PC
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl.pc <= RESET_PC;
      end else if (advance && !bubble) begin
         ctrl.pc <= cur_pc;
      end
   end

   assign busy_o = held_q || ctrl.flush;

   a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
      issue_i |-> !busy_o);

   a_valid_not_nop: assert property (@(posedge clk) disable iff (rst)
      ctrl.valid |-> (ctrl.opc != OPC_NOP));

endmodule

`default_nettype wire

// File: hdl/ctrl_commit.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_commit (
   input  wire logic                     clk,
   input  wire logic                     rst,
   exec_ctrl_if.commit                   ctrl,
   output logic                          wb_we_o,
   output logic [exec_pkg::REG_AW-1:0]   wb_addr_o,
   output logic [exec_pkg::DATA_W-1:0]   wb_data_o,
   output logic                          flag_o,
   output logic                          except_o,
   output exec_pkg::cause_e              cause_o,
   output logic [exec_pkg::DATA_W-1:0]   epc_o,
   output logic                          redirect_o,
   output logic [exec_pkg::DATA_W-1:0]   redirect_pc_o
);
   import exec_pkg::*;

   logic              exc_any;
   logic              commit_ok;
   cause_e            cause;
   logic [DATA_W-1:0] exc_vector;
   logic              flag_q;

   // first match in priority order wins
   always_comb begin
      if (ctrl.exc.ibus_err) begin
         cause = CAUSE_IBUS_ERR;
      end else if (ctrl.exc.ibus_align) begin
         cause = CAUSE_IBUS_ALIGN;
      end else if (ctrl.exc.illegal) begin
         cause = CAUSE_ILLEGAL;
      end else if (ctrl.exc.syscall) begin
         cause = CAUSE_SYSCALL;
      end else if (ctrl.exc.trap) begin
         cause = CAUSE_TRAP;
      end else if (ctrl.exc.dbus) begin
         cause = CAUSE_DBUS;
      end else if (ctrl.exc.align) begin
         cause = CAUSE_ALIGN;
      end else begin
         cause = CAUSE_NONE;
      end
   end

   assign exc_any   = ctrl.valid && (ctrl.exc != '0);
   assign commit_ok = ctrl.valid && !exc_any;

   assign except_o   = exc_any;
   assign cause_o    = exc_any ? cause : CAUSE_NONE;
   assign epc_o      = ctrl.pc;
   assign ctrl.flush = exc_any;

   assign exc_vector = EXC_BASE + DATA_W'({cause, 8'h00});

   assign wb_we_o   = commit_ok && ctrl.wb;
   assign wb_addr_o = ctrl.rd;
   assign wb_data_o = ctrl.result;

   // the target bus carries the vector while an exception is raised
   assign redirect_o    = commit_ok && (ctrl.opc == OPC_JR);
   assign redirect_pc_o = exc_any ? exc_vector : ctrl.rfb;

   always_ff @(posedge clk) begin
      if (rst) begin
         flag_q <= 1'b0;
      end else if (commit_ok) begin
         if (ctrl.flag_set) begin
            flag_q <= 1'b1;
         end else if (ctrl.flag_clear) begin
            flag_q <= 1'b0;
         end
      end
   end

   assign flag_o = flag_q;

   a_wb_or_except: assert property (@(posedge clk) disable iff (rst)
      !(wb_we_o && except_o));

endmodule

`default_nettype wire

// File: hdl/exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module exec_top (
   input  wire logic                        clk,
   input  wire logic                        rst,
   // issue port, one strobe per decoded instruction
   input  wire logic                        issue_i,
   input  wire exec_pkg::insn_u             insn_i,
   input  wire logic [exec_pkg::DATA_W-1:0] opa_i,
   input  wire logic [exec_pkg::DATA_W-1:0] opb_i,
   input  wire logic [exec_pkg::DATA_W-1:0] pc_i,
   input  wire logic                        ibus_err_i,
   output logic                             busy_o,
   // register file write
   output logic                             wb_we_o,
   output logic [exec_pkg::REG_AW-1:0]      wb_addr_o,
   output logic [exec_pkg::DATA_W-1:0]      wb_data_o,
   output logic                             flag_o,
   // exception and redirect
   output logic                             except_o,
   output exec_pkg::cause_e                 cause_o,
   output logic [exec_pkg::DATA_W-1:0]      epc_o,
   output logic                             redirect_o,
   output logic [exec_pkg::DATA_W-1:0]      redirect_pc_o
);

   exec_ctrl_if u_ctrl_if ();

   execute_ctrl u_execute_ctrl (
      .clk        (clk),
      .rst        (rst),
      .issue_i    (issue_i),
      .insn_i     (insn_i),
      .opa_i      (opa_i),
      .opb_i      (opb_i),
      .pc_i       (pc_i),
      .ibus_err_i (ibus_err_i),
      .busy_o     (busy_o),
      .ctrl       (u_ctrl_if)
   );

   ctrl_commit u_ctrl_commit (
      .clk           (clk),
      .rst           (rst),
      .ctrl          (u_ctrl_if),
      .wb_we_o       (wb_we_o),
      .wb_addr_o     (wb_addr_o),
      .wb_data_o     (wb_data_o),
      .flag_o        (flag_o),
      .except_o      (except_o),
      .cause_o       (cause_o),
      .epc_o         (epc_o),
      .redirect_o    (redirect_o),
      .redirect_pc_o (redirect_pc_o)
   );

endmodule

`default_nettype wire

// File: tests/tb_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_exec_top;
   import exec_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int SEED         = 18769;
   localparam int N_INSN       = 2000;
   localparam int CYC_PER_INSN = 40;

   typedef enum logic [1:0] {EXP_WB, EXP_EXC, EXP_REDIR} exp_kind_e;

   // data holds the wb value, the epc or the jump target
   typedef struct packed {
      exp_kind_e         kind;
      logic [REG_AW-1:0] rd;
      logic [DATA_W-1:0] data;
      cause_e            cause;
   } exp_commit_s;

   logic              clk = 1'b0;
   logic              rst;
   logic              issue_i;
   insn_u             insn_i;
   logic [DATA_W-1:0] opa_i;
   logic [DATA_W-1:0] opb_i;
   logic [DATA_W-1:0] pc_i;
   logic              ibus_err_i;
   logic              busy_o;
   logic              wb_we_o;
   logic [REG_AW-1:0] wb_addr_o;
   logic [DATA_W-1:0] wb_data_o;
   logic              flag_o;
   logic              except_o;
   cause_e            cause_o;
   logic [DATA_W-1:0] epc_o;
   logic              redirect_o;
   logic [DATA_W-1:0] redirect_pc_o;

   // reference state
   logic [DATA_W-1:0] model_mem [MEM_WORDS];
   logic              model_flag;
   exp_commit_s       exp_q [$];
   exp_commit_s       mon_ent;
   string             test_name;

   exec_top u_dut (
      .clk           (clk),
      .rst           (rst),
      .issue_i       (issue_i),
      .insn_i        (insn_i),
      .opa_i         (opa_i),
      .opb_i         (opb_i),
      .pc_i          (pc_i),
      .ibus_err_i    (ibus_err_i),
      .busy_o        (busy_o),
      .wb_we_o       (wb_we_o),
      .wb_addr_o     (wb_addr_o),
      .wb_data_o     (wb_data_o),
      .flag_o        (flag_o),
      .except_o      (except_o),
      .cause_o       (cause_o),
      .epc_o         (epc_o),
      .redirect_o    (redirect_o),
      .redirect_pc_o (redirect_pc_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_run();
      $display("** FAIL **");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic report_mismatch(input string what, input logic [DATA_W-1:0] exp,
                                  input logic [DATA_W-1:0] act);
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
      stop_run();
   endtask

   task automatic check_strobes(input logic [2:0] exp);
      if ({wb_we_o, except_o, redirect_o} !== exp) begin
         report_mismatch("strobes wb/except/redirect", 32'(exp),
                         32'({wb_we_o, except_o, redirect_o}));
      end
   endtask

   task automatic check_wb(input logic [REG_AW-1:0] addr, input logic [DATA_W-1:0] data);
      if (wb_addr_o !== addr) begin
         report_mismatch("wb_addr_o", 32'(addr), 32'(wb_addr_o));
      end else if (wb_data_o !== data) begin
         report_mismatch("wb_data_o", data, wb_data_o);
      end
   endtask

   task automatic check_except(input cause_e cause, input logic [DATA_W-1:0] pc);
      logic [DATA_W-1:0] vec;
      vec = EXC_BASE + 32'(cause) * 32'h100;
      if (cause_o !== cause) begin
         report_mismatch("cause_o", 32'(cause), 32'(cause_o));
      end else if (epc_o !== pc) begin
         report_mismatch("epc_o", pc, epc_o);
      end else if (redirect_pc_o !== vec) begin
         report_mismatch("exception vector", vec, redirect_pc_o);
      end
   endtask

   task automatic check_redirect(input logic [DATA_W-1:0] target);
      if (redirect_pc_o !== target) begin
         report_mismatch("redirect_pc_o", target, redirect_pc_o);
      end
   endtask

   task automatic check_flag(input logic val);
      if (flag_o !== val) begin
         report_mismatch("flag_o", 32'(val), 32'(flag_o));
      end
   endtask

   task automatic check_busy_cycles(input int exp, input int act);
      if (act != exp) begin
         report_mismatch("busy cycles", 32'(exp), 32'(act));
      end
   endtask

   // executes one instruction on the model and queues its commit
   task automatic model_execute(input logic [31:0] word, input logic [DATA_W-1:0] a,
                                input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] pc,
                                input logic ierr, output int busy_exp);
      opcode_e           opc;
      logic [DATA_W-1:0] addr;
      logic              is_mem;
      logic              dbus;
      logic              align;
      cause_e            cause;
      exp_commit_s       ent;
      opc    = opcode_e'(word[31:27]);
      is_mem = (opc == OPC_LW) || (opc == OPC_SW);
      addr   = a + {{16{word[15]}}, word[15:0]};
      dbus   = is_mem && (addr >= 32'd256);
      align  = is_mem && (addr[1:0] != 2'b00);
      if (ierr) cause = CAUSE_IBUS_ERR;
      else if ((opc == OPC_JR) && (b[1:0] != 2'b00)) cause = CAUSE_IBUS_ALIGN;
      else if (opc > OPC_TRAP) cause = CAUSE_ILLEGAL;
      else if (opc == OPC_SYS) cause = CAUSE_SYSCALL;
      else if (opc == OPC_TRAP) cause = CAUSE_TRAP;
      else if (dbus) cause = CAUSE_DBUS;
      else if (align) cause = CAUSE_ALIGN;
      else cause = CAUSE_NONE;
      busy_exp  = (opc == OPC_MUL) ? 32 : (is_mem ? 1 : 0);
      ent.kind  = EXP_WB;
      ent.rd    = word[26:22];
      ent.data  = '0;
      ent.cause = cause;
      if (opc == OPC_NOP) begin
         // a bubble never reaches commit
         busy_exp = 0;
      end else if (cause != CAUSE_NONE) begin
         busy_exp++;
         ent.kind = EXP_EXC;
         ent.data = pc;
         exp_q.push_back(ent);
      end else begin
         case (opc)
            OPC_ADD:   ent.data = a + b;
            OPC_SUB:   ent.data = a - b;
            OPC_AND:   ent.data = a & b;
            OPC_OR:    ent.data = a | b;
            OPC_XOR:   ent.data = a ^ b;
            OPC_SLL:   ent.data = a << b[4:0];
            OPC_SRL:   ent.data = a >> b[4:0];
            OPC_MUL:   ent.data = a * b;
            OPC_LW:    ent.data = model_mem[addr[7:2]];
            OPC_SFEQ:  model_flag = (a == b);
            OPC_SFLTU: model_flag = (a < b);
            default:   ent.data = '0;
         endcase
         if (opc == OPC_JR) begin
            ent.kind = EXP_REDIR;
            ent.data = b;
         end
         if (((opc >= OPC_ADD) && (opc <= OPC_MUL)) || (opc == OPC_LW) || (opc == OPC_JR)) begin
            exp_q.push_back(ent);
         end
      end
      // the data memory only sees its own address faults
      if ((opc == OPC_SW) && !dbus && !align) begin
         model_mem[addr[7:2]] = b;
      end
   endtask

   function automatic logic [31:0] make_word(input logic [4:0] opc, input logic [15:0] offset);
      return {opc, 5'($urandom), 6'($urandom), offset};
   endfunction

   function automatic logic [DATA_W-1:0] rand_pc();
      return $urandom & 32'hffff_fffc;
   endfunction

   // issue one instruction and wait until it has left the pipeline
   task automatic run_insn(input logic [31:0] word, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] pc,
                           input logic ierr);
      int busy_exp;
      int busy_cnt;
      model_execute(word, a, b, pc, ierr, busy_exp);
      @(posedge clk);
      #1;
      if (busy_o) begin
         $display("an issue was due while busy_o was still high");
         stop_run();
      end
      issue_i    = 1'b1;
      insn_i     = word;
      opa_i      = a;
      opb_i      = b;
      pc_i       = pc;
      ibus_err_i = ierr;
      @(posedge clk);
      #1;
      // idle ports carry junk that the DUT must ignore
      issue_i    = 1'b0;
      insn_i     = $urandom;
      opa_i      = $urandom;
      opb_i      = $urandom;
      pc_i       = $urandom;
      ibus_err_i = 1'($urandom);
      busy_cnt   = 0;
      @(negedge clk);
      while (busy_o) begin
         busy_cnt++;
         @(negedge clk);
      end
      check_busy_cycles(busy_exp, busy_cnt);
      @(negedge clk);
      check_flag(model_flag);
      if (exp_q.size() != 0) begin
         $display("%s: an expected commit never appeared", test_name);
         stop_run();
      end
   endtask

   // every strobe pops the oldest expected commit
   always @(negedge clk) begin
      if (!rst && (wb_we_o || except_o || redirect_o)) begin
         if (exp_q.size() == 0) begin
            $display("%s: a commit appeared with no instruction outstanding", test_name);
            stop_run();
         end else begin
            mon_ent = exp_q.pop_front();
            case (mon_ent.kind)
               EXP_WB: begin
                  check_strobes(3'b100);
                  check_wb(mon_ent.rd, mon_ent.data);
               end
               EXP_EXC: begin
                  check_strobes(3'b010);
                  check_except(mon_ent.cause, mon_ent.data);
               end
               default: begin
                  check_strobes(3'b001);
                  check_redirect(mon_ent.data);
               end
            endcase
         end
      end
   end

   initial begin
      repeat (N_INSN * CYC_PER_INSN) @(posedge clk);
      $display("watchdog expired, the tests took too long");
      stop_run();
   end

   initial begin : stimulus
      int                sel;
      logic [4:0]        opc;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic [DATA_W-1:0] tgt;
      logic [15:0]       off;
      logic              ierr;
      void'($urandom(SEED));
      rst        = 1'b1;
      issue_i    = 1'b0;
      insn_i     = '0;
      opa_i      = '0;
      opb_i      = '0;
      pc_i       = '0;
      ibus_err_i = 1'b0;
      model_flag = 1'b0;
      test_name  = "reset";
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_strobes(3'b000);
      check_flag(1'b0);
      if (busy_o !== 1'b0) begin
         $display("busy_o is not low after reset");
         stop_run();
      end
      if (epc_o !== RESET_PC) begin
         report_mismatch("stage pc", RESET_PC, epc_o);
      end

      test_name = "alu_mix";
      for (int i = 0; i < 400; i++) begin
         opc = 5'($urandom_range(7, 0));
         run_insn(make_word(opc, 16'($urandom)), $urandom, $urandom, rand_pc(), 1'b0);
      end

      test_name = "mul";
      for (int i = 0; i < 100; i++) begin
         a = ($urandom_range(1, 0) == 0) ? 32'($urandom_range(255, 0)) : $urandom;
         run_insn(make_word(OPC_MUL, 16'($urandom)), a, $urandom, rand_pc(), 1'b0);
      end

      test_name = "mem";
      // write every word first so that later loads see known data
      for (int w = 0; w < MEM_WORDS; w++) begin
         run_insn(make_word(OPC_SW, 16'd0), 32'(w) << 2, $urandom, rand_pc(), 1'b0);
      end
      for (int i = 0; i < 200; i++) begin
         sel = $urandom_range(7, 0);
         tgt = 32'($urandom_range(63, 0)) << 2;
         if (sel == 0) tgt = tgt | 32'($urandom_range(3, 1));
         else if (sel == 1) tgt = 32'($urandom_range(4095, 256));
         off = 16'($urandom_range(127, 0)) - 16'd64;
         a   = tgt - {{16{off[15]}}, off};
         run_insn(make_word(OPC_SW, off), a, $urandom, rand_pc(), 1'b0);
         run_insn(make_word(OPC_LW, off), a, $urandom, rand_pc(), 1'b0);
      end

      test_name = "flag";
      for (int i = 0; i < 200; i++) begin
         a   = $urandom;
         b   = ($urandom_range(2, 0) == 0) ? a : a + 32'($urandom_range(8, 0)) - 32'd4;
         opc = ($urandom_range(1, 0) == 0) ? OPC_SFEQ : OPC_SFLTU;
         run_insn(make_word(opc, 16'($urandom)), a, b, rand_pc(), 1'b0);
      end

      test_name = "jump";
      for (int i = 0; i < 150; i++) begin
         b = rand_pc();
         if ($urandom_range(3, 0) == 0) b = b | 32'($urandom_range(3, 1));
         run_insn(make_word(OPC_JR, 16'($urandom)), $urandom, b, rand_pc(), 1'b0);
      end

      test_name = "except";
      for (int i = 0; i < 250; i++) begin
         sel = $urandom_range(3, 0);
         case (sel)
            0:       opc = OPC_SYS;
            1:       opc = OPC_TRAP;
            2:       opc = 5'($urandom_range(31, 16));
            default: opc = 5'($urandom_range(31, 0));
         endcase
         ierr = ($urandom_range(2, 0) == 0);
         run_insn(make_word(opc, 16'($urandom)), $urandom, $urandom, rand_pc(), ierr);
      end

      test_name = "random";
      for (int i = 0; i < 400; i++) begin
         opc  = 5'($urandom_range(31, 0));
         off  = 16'($urandom_range(31, 0)) - 16'd16;
         ierr = ($urandom_range(15, 0) == 0);
         a    = 32'($urandom_range(300, 0));
         run_insn(make_word(opc, off), a, $urandom, rand_pc(), ierr);
      end

      if (exp_q.size() != 0) begin
         $display("commits were still outstanding at the end of the run");
         stop_run();
      end else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: exec_ctrl.f
hdl/exec_pkg.sv
hdl/exec_ctrl_if.sv
hdl/exec_alu.sv
hdl/exec_lsu.sv
hdl/execute_ctrl.sv
hdl/ctrl_commit.sv
hdl/exec_top.sv
tests/tb_exec_top.sv

// File: Makefile
TOP := tb_exec_top

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f exec_ctrl.f -o V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f exec_ctrl.f

clean:
	rm -rf obj_dir
